/* compile.f */
rtl/usiBusPkg.sv
rtl/i2cPkg.sv
rtl/i2cCsr.sv
rtl/i2cClkGen.sv
rtl/i2cBitEngine.sv
rtl/i2cKeyPadSeq.sv
rtl/i2cKeyPadTop.sv
verification/i2cSlaveModel.sv
verification/tbI2CKeyPad.sv

/* run.sh */
#!/bin/sh
# Verilator build and run of the keypad poller testbench
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing --top-module tbI2CKeyPad -f compile.f \
	> build.log 2>&1 && ./obj_dir/VtbI2CKeyPad > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

/* verification/tbI2CKeyPad.sv */
/* Testbench for the I2C keypad poller with a behavioral keypad slave.
   Covers register access, SCL timing, key data, NACK and disable over the USI bus. */
`timescale 1ns/10ps

module tbI2CKeyPad
	import usiBusPkg::*;
();

localparam int clkHalf = 4;					// 8 ns clock
localparam int divVal = 3;
localparam int bitCycles = 4 * (divVal + 1);	// One SCL period
localparam int waitLimit = 4 * 40 * bitCycles;	// Per wait, in cycles
localparam int wdogNs = 20 * 40 * bitCycles * 8 + 20000;
localparam int idleWindow = 600;
localparam int keyRounds = 4;
// Event counter selectors
localparam int evStart = 0;
localparam int evStop = 1;
localparam int evWord = 2;
localparam int evNack = 3;

logic        iSysClk;
logic        rst;
logic [31:0] susiWd;
logic [31:0] susiAdrs;
logic        susiWCke;
logic [31:0] susiRd;
logic        susiREd;
logic        sclLow;
logic        sdaLow;
logic        slaveLow;
logic        scl;
logic        sda;
logic        nackAdrs;
logic [15:0] keyVal;
logic [15:0] startCnt;
logic [15:0] stopCnt;
logic [15:0] wordCnt;
logic [15:0] nackCnt;
logic [31:0] lfsrState;
logic [31:0] rdData;
logic        rdValid;
logic [15:0] keyNext;
logic [15:0] lastKey;		// Last word the slave served with ACK
int          errCnt;
int          checkCnt;
int          target;
int          busyCycles;

// Open-drain wired-AND
assign scl = !sclLow;
assign sda = !(sdaLow || slaveLow);

i2cKeyPadTop UUT (
	.iSysClk(iSysClk), .rst(rst), .susiWd(susiWd), .susiAdrs(susiAdrs),
	.susiWCke(susiWCke), .susiRd(susiRd), .susiREd(susiREd),
	.sclLow(sclLow), .sdaLow(sdaLow), .sdaIn(sda)
);

i2cSlaveModel uSlave (
	.iSysClk(iSysClk), .rst(rst), .scl(scl), .sda(sda), .nackAdrs(nackAdrs),
	.keyVal(keyVal), .sdaLow(slaveLow), .startCnt(startCnt), .stopCnt(stopCnt),
	.wordCnt(wordCnt), .nackCnt(nackCnt)
);

initial
begin
	iSysClk = 1'b0;
	forever #(clkHalf) iSysClk = ~iSysClk;
end

initial
begin
	#(wdogNs);
	$display("Watchdog expired before the tests finished");
	$display("Simulation failed");
	$finish;
end

//------------------------------------------------------------
// Helpers
//------------------------------------------------------------
function automatic logic [31:0] regAdrs(input logic [7:0] blk, input logic [7:0] ofs);
	return {16'h0000, blk, ofs};
endfunction

// Fibonacci taps 32 22 2 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic int eventCount(input int sel);
	case (sel)
		evStart: return int'(startCnt);
		evStop: return int'(stopCnt);
		evWord: return int'(wordCnt);
		default: return int'(nackCnt);
	endcase
endfunction

task automatic randomKey(output logic [15:0] key);
	key = 16'h0000;
	for (int i = 0; i < 16; i++)
	begin
		lfsrState = lfsrNext(lfsrState);	// One step per bit
		key = {key[14:0], lfsrState[0]};
	end
endtask

task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
	checkCnt++;
	assert (act === exp)
	else
	begin
		errCnt++;
		$display("[FAIL] %s expected %h actual %h", name, exp, act);
	end
endtask

task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
	@(posedge iSysClk);
	susiAdrs <= adrs;
	susiWd <= data;
	susiWCke <= 1'b1;
	@(posedge iSysClk);
	susiWCke <= 1'b0;
	susiAdrs <= '0;
endtask

// Data and valid sampled mid-cycle, one cycle after the address
task automatic busRead(input logic [31:0] adrs, input logic [31:0] wd,
	output logic [31:0] data, output logic valid);
	@(posedge iSysClk);
	susiAdrs <= adrs;
	susiWd <= wd;
	@(posedge iSysClk);
	@(negedge iSysClk);
	data = susiRd;
	valid = susiREd;
	@(posedge iSysClk);
	susiAdrs <= '0;
endtask

task automatic checkBusRead(input string name, input logic [7:0] ofs, input logic [31:0] exp);
	logic [31:0] data;
	logic        valid;
	busRead(regAdrs(i2cBlockAdrs, ofs), 32'hDEAD0000, data, valid);
	checkEq(name, exp, data);
	checkEq({name, "Valid"}, 32'h1, {31'h0, valid});
endtask

task automatic waitEvents(input string what, input int sel, input int goal);
	int n;
	n = 0;
	while (eventCount(sel) < goal && n < waitLimit)
	begin
		@(negedge iSysClk);
		n++;
	end
	assert (eventCount(sel) >= goal)
	else
	begin
		errCnt++;
		$display("Timed out waiting for %s on the I2C bus", what);
	end
endtask

// Falls 2 to 10 close the address bits and their ACK
task automatic measureSclPeriod(input int startGoal);
	int   falls;
	int   lastFall;
	int   cyc;
	logic sclPrev;
	waitEvents("first start", evStart, startGoal);
	falls = 0;
	lastFall = 0;
	cyc = 0;
	sclPrev = scl;
	while (falls < 10 && cyc < waitLimit)
	begin
		@(negedge iSysClk);
		cyc++;
		if (sclPrev && !scl)
		begin
			falls++;
			if (falls >= 3)
				checkEq("sclPeriod", bitCycles, cyc - lastFall);
			lastFall = cyc;
		end
		sclPrev = scl;
	end
	assert (falls == 10)
	else
	begin
		errCnt++;
		$display("SCL stopped toggling inside the address byte");
	end
endtask

//------------------------------------------------------------
// Test sequence
//------------------------------------------------------------
initial
begin
	errCnt = 0;
	checkCnt = 0;
	lfsrState = 32'h8ef9;
	rst = 1'b1;
	susiWd = '0;
	susiAdrs = '0;
	susiWCke = 1'b0;
	nackAdrs = 1'b0;
	keyVal = 16'h0000;
	lastKey = 16'h0000;
	repeat (3) @(posedge iSysClk);
	rst <= 1'b0;

	// Reset values
	checkBusRead("rstEn", csrEnOfs, 32'h0);
	checkBusRead("rstDiv", csrDivOfs, 32'h0000FFFF);
	checkBusRead("rstKeyPad", csrKeyPadOfs, 32'h0);
	checkBusRead("rstSeqComp", csrSeqCompOfs, 32'h0);
	checkEq("rstLines", 32'h3, {30'h0, scl, sda});

	// Register access and block select
	busWrite(regAdrs(i2cBlockAdrs, csrDivOfs), 32'h5A3C);
	checkBusRead("divWr", csrDivOfs, 32'h5A3C);
	busWrite(regAdrs(8'h05, csrDivOfs), 32'h1111);
	busWrite(regAdrs(8'h05, csrEnOfs), 32'h1);
	checkBusRead("divOther", csrDivOfs, 32'h5A3C);
	checkBusRead("enOther", csrEnOfs, 32'h0);
	busRead(regAdrs(8'h07, csrEnOfs), 32'hC0FFEE01, rdData, rdValid);
	checkEq("chainData", 32'hC0FFEE01, rdData);
	checkEq("chainValid", 32'h0, {31'h0, rdValid});
	busWrite(regAdrs(i2cBlockAdrs, csrDivOfs), divVal);
	checkBusRead("divSet", csrDivOfs, divVal);

	// Enable polling and time SCL
	randomKey(keyNext);
	keyVal <= keyNext;
	@(negedge iSysClk);
	target = int'(startCnt) + 1;
	busWrite(regAdrs(i2cBlockAdrs, csrEnOfs), 32'h1);
	checkBusRead("enSet", csrEnOfs, 32'h1);
	measureSclPeriod(target);

	// Key words, high byte first
	for (int r = 0; r < keyRounds; r++)
	begin
		randomKey(keyNext);
		@(negedge iSysClk);
		target = int'(wordCnt) + 2;		// Second word is surely the new one
		@(posedge iSysClk);
		keyVal <= keyNext;
		waitEvents("key words", evWord, target);
		target = int'(startCnt) + 1;
		waitEvents("next start", evStart, target);
		checkBusRead("keySeqComp", csrSeqCompOfs, 32'h1);
		checkBusRead("keyPad", csrKeyPadOfs, {16'h0000, keyNext});
		lastKey = keyNext;
	end

	// Address NACK
	@(negedge iSysClk);
	target = int'(nackCnt) + 1;
	@(posedge iSysClk);
	nackAdrs <= 1'b1;
	waitEvents("address NACK", evNack, target);
	target = int'(startCnt) + 1;
	waitEvents("start after NACK", evStart, target);
	checkBusRead("nackSeqComp", csrSeqCompOfs, 32'h0);
	checkBusRead("nackKeyPad", csrKeyPadOfs, {16'h0000, lastKey});
	@(posedge iSysClk);
	nackAdrs <= 1'b0;

	// Disable right after a start so a full sequence remains
	@(negedge iSysClk);
	target = int'(startCnt) + 1;
	waitEvents("start before disable", evStart, target);
	busWrite(regAdrs(i2cBlockAdrs, csrEnOfs), 32'h0);
	@(negedge iSysClk);
	target = int'(stopCnt) + 1;
	waitEvents("stop after disable", evStop, target);
	busyCycles = 0;
	repeat (idleWindow)
	begin
		@(negedge iSysClk);
		if (!scl || !sda)
			busyCycles++;
	end
	checkEq("idleBusy", 32'h0, busyCycles);

	$display("%0d checks, %0d errors", checkCnt, errCnt);
	if (errCnt == 0)
		$display("Simulation passed");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

/* verification/i2cSlaveModel.sv */
/* Behavioral keypad slave on the resolved I2C lines, clocked by the system clock.
   Serves keyVal high byte first, or NACKs its address while nackAdrs is set. */
`timescale 1ns/10ps

module i2cSlaveModel
	import i2cPkg::*;
(
	input  logic        iSysClk,
	input  logic        rst,
	input  logic        scl,		// Resolved bus lines
	input  logic        sda,
	input  logic        nackAdrs,	// Refuse the next address
	input  logic [15:0] keyVal,
	output logic        sdaLow,
	// Bus event counters for the testbench
	output logic [15:0] startCnt,
	output logic [15:0] stopCnt,
	output logic [15:0] wordCnt,	// Words fully sent
	output logic [15:0] nackCnt
);

localparam logic [1:0] modeIdle = 2'd0;
localparam logic [1:0] modeAdrs = 2'd1;
localparam logic [1:0] modeTx = 2'd2;

logic [1:0]  mode;
logic        sclQ;
logic        sdaQ;
logic [3:0]  bitCnt;		// SCL rises in this frame
logic [7:0]  adrsIn;
logic        adrsMatch;
logic        adrsAck;
logic [15:0] txWord;		// Latched at address ACK
logic        byteIdx;		// 0 high byte, 1 low byte
logic [7:0]  curByte;
logic        mAck;			// Master ACK after a byte

assign adrsMatch = adrsIn == {keyPadSlaveAdrs, 1'b1};
assign curByte = byteIdx ? txWord[7:0] : txWord[15:8];

always_ff @(posedge iSysClk)
begin
	sclQ <= scl;
	sdaQ <= sda;
	if (rst)
	begin
		mode <= modeIdle;
		sdaLow <= 1'b0;
		bitCnt <= 4'd0;
		startCnt <= 16'd0;
		stopCnt <= 16'd0;
		wordCnt <= 16'd0;
		nackCnt <= 16'd0;
	end
	else if (scl && sclQ && sdaQ && !sda)
	begin
		// Start condition
		mode <= modeAdrs;
		bitCnt <= 4'd0;
		sdaLow <= 1'b0;
		startCnt <= startCnt + 16'd1;
	end
	else if (scl && sclQ && !sdaQ && sda)
	begin
		mode <= modeIdle;	// Stop condition
		sdaLow <= 1'b0;
		stopCnt <= stopCnt + 16'd1;
	end
	else if (scl && !sclQ)
	begin
		// SCL rise, sample
		bitCnt <= bitCnt + 4'd1;
		if (mode == modeAdrs && bitCnt < 4'd8)
			adrsIn <= {adrsIn[6:0], sda};
		if (mode == modeTx && bitCnt == 4'd8)
			mAck <= !sda;
	end
	else if (!scl && sclQ && mode == modeAdrs)
	begin
		if (bitCnt == 4'd8)
		begin
			adrsAck <= adrsMatch && !nackAdrs;
			sdaLow <= adrsMatch && !nackAdrs;	// ACK slot
			if (adrsMatch && nackAdrs)
				nackCnt <= nackCnt + 16'd1;
		end
		else if (bitCnt == 4'd9 && adrsAck)
		begin
			mode <= modeTx;
			txWord <= keyVal;
			byteIdx <= 1'b0;
			bitCnt <= 4'd0;
			sdaLow <= !keyVal[15];	// First data bit
		end
		else if (bitCnt == 4'd9)
		begin
			mode <= modeIdle;
			sdaLow <= 1'b0;
		end
	end
	else if (!scl && sclQ && mode == modeTx)
	begin
		if (bitCnt >= 4'd1 && bitCnt <= 4'd7)
			sdaLow <= !curByte[3'd7 - bitCnt[2:0]];
		else if (bitCnt == 4'd8)
			sdaLow <= 1'b0;		// Master owns the ACK bit
		else if (bitCnt == 4'd9 && !byteIdx && mAck)
		begin
			byteIdx <= 1'b1;
			bitCnt <= 4'd0;
			sdaLow <= !txWord[7];
		end
		else if (bitCnt == 4'd9)
		begin
			mode <= modeIdle;
			sdaLow <= 1'b0;
			if (byteIdx)
				wordCnt <= wordCnt + 16'd1;
		end
	end
end

endmodule

/* rtl/i2cKeyPadTop.sv */
/* Top level of the I2C keypad poller, wiring CSR, sequencer, bit engine and clock generator.
   SCL and SDA leave as drive-low outputs with SDA sensed back on sdaIn. */
`timescale 1ns/10ps

module i2cKeyPadTop
	import usiBusPkg::*;
	import i2cPkg::*;
(
	input  logic                  iSysClk,
	input  logic                  rst,
	// USI bus
	input  logic [busDataBit-1:0] susiWd,
	input  logic [busAdrsBit-1:0] susiAdrs,
	input  logic                  susiWCke,
	output logic [busDataBit-1:0] susiRd,
	output logic                  susiREd,
	// Open-drain I2C
	output logic                  sclLow,
	output logic                  sdaLow,
	input  logic                  sdaIn
);

//----------------------------------------------------------
// Internal nets
//----------------------------------------------------------
logic                 i2cEn;
logic [i2cDivBit-1:0] i2cDiv;
logic [15:0]          keyPad;
logic                 seqComp;
logic [i2cCmdBit-1:0] cmd;
logic                 cmdValid;
logic                 cmdBusy;
logic [7:0]           rxByte;
logic                 ackErr;
logic                 qTick;
logic                 run;

i2cCsr uCsr (
	.iSysClk(iSysClk), .rst(rst), .susiWd(susiWd), .susiAdrs(susiAdrs), .susiWCke(susiWCke),
	.susiRd(susiRd), .susiREd(susiREd), .keyPadIn(keyPad), .seqCompIn(seqComp),
	.i2cEn(i2cEn), .i2cDiv(i2cDiv)
);

i2cKeyPadSeq uSeq (
	.iSysClk(iSysClk), .rst(rst), .i2cEn(i2cEn), .cmd(cmd), .cmdValid(cmdValid),
	.cmdBusy(cmdBusy), .rxByte(rxByte), .ackErr(ackErr), .keyPad(keyPad), .seqComp(seqComp)
);

i2cBitEngine uEngine (
	.iSysClk(iSysClk), .rst(rst), .cmd(cmd), .cmdValid(cmdValid), .cmdBusy(cmdBusy),
	.rxByte(rxByte), .ackErr(ackErr), .qTick(qTick), .run(run),
	.sclLow(sclLow), .sdaLow(sdaLow), .sdaIn(sdaIn)
);

i2cClkGen uClkGen (
	.iSysClk(iSysClk), .rst(rst), .run(run), .i2cDiv(i2cDiv), .qTick(qTick)
);

endmodule

/* rtl/i2cKeyPadSeq.sv */
/* Keypad polling sequencer driving the bit engine while enabled.
   Runs start, address, two reads and stop, then publishes the key word and flag. */
`timescale 1ns/10ps

module i2cKeyPadSeq
	import i2cPkg::*;
(
	input  logic                 iSysClk,
	input  logic                 rst,
	input  logic                 i2cEn,		// Keep polling
	// Bit engine
	output logic [i2cCmdBit-1:0] cmd,		// Also the sequencer step
	output logic                 cmdValid,
	input  logic                 cmdBusy,
	input  logic [7:0]           rxByte,
	input  logic                 ackErr,
	// Status
	output logic [15:0]          keyPad,
	output logic                 seqComp
);

logic                 stepDone;		// Engine idle, last command finished
logic [i2cCmdBit-1:0] nextCmd;
logic [1:0]           byteCnt;
logic [1:0]           nextByteCnt;
logic [7:0]           hiByte;		// First byte received
logic                 nackSeen;		// Address NACK this sequence

assign stepDone = !cmdValid && !cmdBusy;

//----------------------------------------------------------
// Next step
//----------------------------------------------------------
always_comb
begin
	nextCmd = i2cCmdIdle;
	nextByteCnt = byteCnt;
	case (cmd)
		i2cCmdIdle:
			nextCmd = i2cEn ? i2cCmdStart : i2cCmdIdle;
		i2cCmdStart:
			nextCmd = i2cCmdAdrsRd;
		i2cCmdAdrsRd:
		begin
			nextByteCnt = 2'd0;
			nextCmd = ackErr ? i2cCmdStop : i2cCmdReadAck;	// NACK skips the reads
		end
		i2cCmdReadAck:
		begin
			nextByteCnt = byteCnt + 2'd1;
			// Final byte gets the NACK
			if (nextByteCnt == keyPadByteCnt - 2'd1)
				nextCmd = i2cCmdReadNack;
			else
				nextCmd = i2cCmdReadAck;
		end
		i2cCmdReadNack:
			nextCmd = i2cCmdStop;
		i2cCmdStop:
			nextCmd = i2cEn ? i2cCmdStart : i2cCmdIdle;	// Back to back polls
		default:
			nextCmd = i2cCmdIdle;
	endcase
end

always_ff @(posedge iSysClk)
begin
	if (rst)
	begin
		cmd <= i2cCmdIdle;
		cmdValid <= 1'b0;
		byteCnt <= 2'd0;
		nackSeen <= 1'b0;
		keyPad <= 16'h0000;
		seqComp <= 1'b0;
	end
	else
	begin
		cmdValid <= 1'b0;
		if (stepDone)
		begin
			cmd <= nextCmd;
			cmdValid <= nextCmd != i2cCmdIdle;	// Issue straight away
			byteCnt <= nextByteCnt;
			if (cmd == i2cCmdAdrsRd)
				nackSeen <= ackErr;
			if (cmd == i2cCmdReadNack)
				keyPad <= {hiByte, rxByte};
			if (cmd == i2cCmdStop)
				seqComp <= !nackSeen;		// End of sequence marker
		end
	end
end

// High byte held until the low byte lands
always_ff @(posedge iSysClk)
begin
	if (stepDone && (cmd == i2cCmdReadAck))
		hiByte <= rxByte;
end

endmodule

/* rtl/i2cBitEngine.sv */
/* I2C bit engine for start, stop, address write and byte read commands.
   Steps four quarter phases per bit on qTick and drives open-drain SCL and SDA. */
`timescale 1ns/10ps

module i2cBitEngine
	import i2cPkg::*;
(
	input  logic                 iSysClk,
	input  logic                 rst,
	// Command side
	input  logic [i2cCmdBit-1:0] cmd,
	input  logic                 cmdValid,
	output logic                 cmdBusy,
	// Results, valid while cmdBusy is low
	output logic [7:0]           rxByte,
	output logic                 ackErr,		// Address NACKed
	// Clock generator
	input  logic                 qTick,
	output logic                 run,
	// I2C pins, high means pull low
	output logic                 sclLow,
	output logic                 sdaLow,
	input  logic                 sdaIn
);

logic [i2cCmdBit-1:0] curCmd;	// Command in progress
logic [1:0]           phase;	// Quarter within the bit
logic [3:0]           bitCnt;	// 0..7 data, 8 ACK
logic [7:0]           shReg;	// Address out, data in

logic accept;
logic isStart;
logic isStop;
logic isAdrs;
logic ackBit;
logic lastBit;
logic bitDrive;		// SDA pull for the current bit
logic sampleEn;

assign accept = cmdValid && !cmdBusy && (cmd != i2cCmdIdle);
assign isStart = curCmd == i2cCmdStart;
assign isStop = curCmd == i2cCmdStop;
assign isAdrs = curCmd == i2cCmdAdrsRd;
assign ackBit = bitCnt == 4'd8;
// Start and stop are a single bit slot
assign lastBit = (isStart || isStop) ? (bitCnt == 4'd0) : ackBit;
assign bitDrive = ackBit ? (curCmd == i2cCmdReadAck) : !shReg[7];
assign sampleEn = cmdBusy && qTick && (phase == 2'd2) && !isStart && !isStop && !ackBit;
assign run = cmdBusy;
assign rxByte = shReg;

//----------------------------------------------------------
// Phase sequencer
//----------------------------------------------------------
always_ff @(posedge iSysClk)
begin
	if (rst)
	begin
		cmdBusy <= 1'b0;
		curCmd <= i2cCmdIdle;
		phase <= 2'd0;
		bitCnt <= 4'd0;
		sclLow <= 1'b0;		// Bus released
		sdaLow <= 1'b0;
		ackErr <= 1'b0;
	end
	else if (accept)
	begin
		cmdBusy <= 1'b1;
		curCmd <= cmd;
		phase <= 2'd0;
		bitCnt <= 4'd0;
	end
	else if (cmdBusy && qTick)
	begin
		phase <= phase + 2'd1;
		case (phase)
			2'd0:
			begin
				// SCL is low here except before a start
				if (isStop)
					sdaLow <= 1'b1;
				else if (!isStart)
					sdaLow <= bitDrive;
			end
			2'd1:
				sclLow <= 1'b0;		// SCL rises
			2'd2:
			begin
				if (isStart)
					sdaLow <= 1'b1;		// Start edge
				else if (isStop)
					sdaLow <= 1'b0;		// Stop edge
				else if (isAdrs && ackBit)
					ackErr <= sdaIn;	// High means no slave
			end
			default:
			begin
				if (!isStop)
					sclLow <= 1'b1;		// Hold SCL low between commands
				bitCnt <= bitCnt + 4'd1;
				if (lastBit)
					cmdBusy <= 1'b0;
			end
		endcase
	end
end

// Shift register, MSB first both ways
always_ff @(posedge iSysClk)
begin
	if (accept)
		shReg <= (cmd == i2cCmdAdrsRd) ? {keyPadSlaveAdrs, 1'b1} : 8'hFF;
	else if (sampleEn)
		shReg <= {shReg[6:0], sdaIn};
end

endmodule

/* rtl/i2cClkGen.sv */
/* Quarter-bit tick generator for the I2C bit engine.
   Pulses qTick every i2cDiv+1 cycles while run is high. */
`timescale 1ns/10ps

module i2cClkGen
	import i2cPkg::*;
(
	input  logic                 iSysClk,
	input  logic                 rst,
	input  logic                 run,		// Engine busy
	input  logic [i2cDivBit-1:0] i2cDiv,	// Cycles per quarter bit, minus one
	output logic                 qTick
);

logic [i2cDivBit-1:0] divCnt;	// Counts down to the next tick

//----------------------------------------------------------
// Down counter
//----------------------------------------------------------
always_ff @(posedge iSysClk)
begin
	if (rst || !run)
	begin
		// Parked at full count, first tick a whole interval after start
		divCnt <= i2cDiv;
		qTick <= 1'b0;
	end
	else if (divCnt == '0)
	begin
		divCnt <= i2cDiv;		// Reload
		qTick <= 1'b1;
	end
	else
	begin
		divCnt <= divCnt - 1'b1;
		qTick <= 1'b0;
	end
end

// SCL period works out to 4*(i2cDiv+1) cycles

endmodule

/* rtl/i2cCsr.sv */
/* Register block of the keypad poller on the USI bus.
   Holds enable and divider, captures key status and answers reads one cycle later. */
`timescale 1ns/10ps

module i2cCsr
	import usiBusPkg::*;
	import i2cPkg::*;
(
	input  logic                  iSysClk,
	input  logic                  rst,
	// Bus write side
	input  logic [busDataBit-1:0] susiWd,
	input  logic [busAdrsBit-1:0] susiAdrs,
	input  logic                  susiWCke,		// One-cycle write strobe
	// Bus read side
	output logic [busDataBit-1:0] susiRd,
	output logic                  susiREd,		// High the cycle after a block hit
	// Status from the sequencer
	input  logic [15:0]           keyPadIn,
	input  logic                  seqCompIn,
	// Control to the I2C logic
	output logic                  i2cEn,
	output logic [i2cDivBit-1:0]  i2cDiv
);

logic        blockHit;		// Address bits [15:8] select this block
logic [7:0]  regOfs;
logic        enWr;
logic        divWr;
logic [15:0] keyPadReg;		// Captured status
logic        seqCompReg;

assign blockHit = susiAdrs[blockAdrsBit+7:8] == i2cBlockAdrs;
assign regOfs = susiAdrs[7:0];
assign enWr = susiWCke && blockHit && (regOfs == csrEnOfs);
assign divWr = susiWCke && blockHit && (regOfs == csrDivOfs);

//----------------------------------------------------------
// Write registers
//----------------------------------------------------------
always_ff @(posedge iSysClk)
begin
	if (rst)
	begin
		i2cEn <= 1'b0;
		i2cDiv <= '1;		// Slowest SCL until software sets it
	end
	else
	begin
		if (enWr)
			i2cEn <= susiWd[0];
		if (divWr)
			i2cDiv <= susiWd[i2cDivBit-1:0];
	end
end

// Status follows the sequencer with one stage
always_ff @(posedge iSysClk)
begin
	if (rst)
	begin
		keyPadReg <= 16'h0000;
		seqCompReg <= 1'b0;
	end
	else
	begin
		keyPadReg <= keyPadIn;
		seqCompReg <= seqCompIn;
	end
end

//----------------------------------------------------------
// Read path
//----------------------------------------------------------
always_ff @(posedge iSysClk)
begin
	if (rst)
		susiREd <= 1'b0;
	else
		susiREd <= blockHit;
end

// Unclaimed addresses pass write data on down the chain
always_ff @(posedge iSysClk)
begin
	if (!blockHit)
		susiRd <= susiWd;
	else
	begin
		case (regOfs)
			csrEnOfs:		susiRd <= {{(busDataBit-1){1'b0}}, i2cEn};
			csrDivOfs:		susiRd <= {{(busDataBit-i2cDivBit){1'b0}}, i2cDiv};
			csrKeyPadOfs:	susiRd <= {{(busDataBit-16){1'b0}}, keyPadReg};
			csrSeqCompOfs:	susiRd <= {{(busDataBit-1){1'b0}}, seqCompReg};
			default:		susiRd <= susiWd;	// Hole in the map
		endcase
	end
end

endmodule

/* rtl/i2cPkg.sv */
/* I2C constants for the keypad poller and the bit engine command codes.
   Shared by the sequencer, bit engine, clock generator, CSR block and slave model. */
package i2cPkg;

	//----------------------------------------------------------
	// Timing and slave
	//----------------------------------------------------------
	localparam int i2cDivBit = 16;					// Divider register width
	localparam logic [6:0] keyPadSlaveAdrs = 7'h20;	// 7-bit keypad address
	localparam logic [1:0] keyPadByteCnt = 2'd2;	// Bytes per poll, high first

	//----------------------------------------------------------
	// Bit engine commands
	//----------------------------------------------------------
	localparam int i2cCmdBit = 3;

	// Nothing issued, also the sequencer rest state
	localparam logic [i2cCmdBit-1:0] i2cCmdIdle = 3'd0;
	localparam logic [i2cCmdBit-1:0] i2cCmdStart = 3'd1;	// SDA falls, SCL high
	// Keypad address plus R bit, then ACK sample
	localparam logic [i2cCmdBit-1:0] i2cCmdAdrsRd = 3'd2;
	localparam logic [i2cCmdBit-1:0] i2cCmdReadAck = 3'd3;	// Byte in, master ACK
	localparam logic [i2cCmdBit-1:0] i2cCmdReadNack = 3'd4;	// Last byte, NACK
	localparam logic [i2cCmdBit-1:0] i2cCmdStop = 3'd5;		// SDA rises, SCL high

	// Each bit is four qTick phases
	//   0 set SDA, 1 release SCL, 2 sample SDA, 3 pull SCL low

endpackage

/* rtl/usiBusPkg.sv */
/* USI register bus widths, I2C block select value and CSR offsets.
   Imported by the CSR block, the top level and the testbench. */
package usiBusPkg;

	//----------------------------------------------------------
	// Bus geometry
	//----------------------------------------------------------
	localparam int busAdrsBit = 32;		// Address width
	localparam int busDataBit = 32;		// Data width

	// Block select field, address bits [15:8]
	localparam int blockAdrsBit = 8;
	localparam logic [blockAdrsBit-1:0] i2cBlockAdrs = 8'h04;	// I2C poller slot

	//----------------------------------------------------------
	// CSR offsets, address bits [7:0]
	//----------------------------------------------------------
	localparam logic [7:0] csrEnOfs = 8'h00;		// Poll enable, bit 0, R/W
	localparam logic [7:0] csrDivOfs = 8'h04;		// Quarter-bit divider, R/W
	// Status words written by hardware
	localparam logic [7:0] csrKeyPadOfs = 8'h80;	// Last good key word, RO
	localparam logic [7:0] csrSeqCompOfs = 8'h84;	// Completion flag, RO

endpackage
